/* Makefile */
# Verilator build and run of the link transmit testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_lumi_tx
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/lumi_link_pkg.sv */
//##########################################################################
// Link geometry of the transmit path: UMI field widths, packet bytes,
// PHY lane width and the vector types built on them
//##########################################################################

package lumi_link_pkg;

   //########################################################################
   // UMI field widths
   //########################################################################
   localparam int CMD_W  = 32;                          // Command word
   localparam int ADDR_W = 64;                          // Dst and src address
   localparam int DATA_W = 128;                         // Data payload
   localparam int PKT_W  = CMD_W + 2 * ADDR_W + DATA_W; // 288 bits

   // Byte counts per packet section
   localparam int PKT_BYTES  = PKT_W / 8;                  // 36
   localparam int HDR_BYTES  = (CMD_W + 2 * ADDR_W) / 8;   // 20
   localparam int CMD_BYTES  = CMD_W / 8;                  // 4
   localparam int DATA_BYTES = DATA_W / 8;                 // 16

   //########################################################################
   // PHY side and counters
   //########################################################################
   localparam int LANE_W    = 64;  // Widest beat, 8 bytes
   localparam int CRDT_W    = 16;  // Credit counter
   localparam int BYTECNT_W = 12;  // Byte and line counts

   // Packet as it sits in the shift register, cmd at the LSB
   typedef logic [PKT_W-1:0]     pkt_t;
   typedef logic [PKT_BYTES-1:0] pkt_mask_t;  // One bit per packet byte
   typedef logic [LANE_W-1:0]    lane_t;
   typedef logic [CRDT_W-1:0]    crdt_t;
   typedef logic [BYTECNT_W-1:0] bytecnt_t;
   typedef logic [1:0]           iowidth_t;   // log2 of bytes per beat

endpackage

/* common/umi_cmd_pkg.sv */
//##########################################################################
// UMI command word layout and the opcode values that decide how many
// bytes a packet puts on the link
//##########################################################################

package umi_cmd_pkg;

   typedef logic [lumi_link_pkg::CMD_W-1:0] cmd_t;
   typedef logic [4:0] opcode_t;
   typedef logic [2:0] size_t;   // log2 of bytes per word
   typedef logic [7:0] len_t;    // Words minus one

   //########################################################################
   // Field positions in the command word
   //########################################################################
   localparam int OP_LSB   = 0;
   localparam int OP_MSB   = 4;
   localparam int SIZE_LSB = 5;
   localparam int SIZE_MSB = 7;
   localparam int LEN_LSB  = 8;
   localparam int LEN_MSB  = 15;

   //########################################################################
   // Opcodes
   //########################################################################
   // Command word alone on the link
   localparam opcode_t OP_INVALID = 5'h00;

   // Header only, no data bytes follow
   localparam opcode_t OP_READ       = 5'h01;
   localparam opcode_t OP_WRITE_RESP = 5'h04;
   localparam opcode_t OP_RDMA       = 5'h07;
   localparam opcode_t OP_USER0      = 5'h0B;
   localparam opcode_t OP_FUTURE0    = 5'h0D;
   localparam opcode_t OP_ERROR      = 5'h0F;

   // Any other opcode carries data

endpackage

/* logic/lumi_credit_tracker.sv */
//##########################################################################
// Counts lines sent per class and grants a class while the remote
// credits cover the next packet; grants always when credits are off
//##########################################################################

module lumi_credit_tracker
  (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     csr_en,          // Low clears the counts
   input  logic                     csr_crdt_en,
   input  lumi_link_pkg::crdt_t     rmt_crdt_req,    // Remote credits, in lines
   input  lumi_link_pkg::crdt_t     rmt_crdt_resp,
   input  lumi_link_pkg::bytecnt_t  req_need,
   input  lumi_link_pkg::bytecnt_t  resp_need,
   input  logic                     beat_sent,
   input  logic                     beat_is_resp,
   output logic                     req_grant,
   output logic                     resp_grant
   );

   import lumi_link_pkg::*;

   crdt_t sent_req;        // Lines already on the link
   crdt_t sent_resp;
   crdt_t avail_req;
   crdt_t avail_resp;
   logic  beat_req;        // Beat leaving this cycle
   logic  beat_resp;

   assign beat_req  = beat_sent & ~beat_is_resp;
   assign beat_resp = beat_sent & beat_is_resp;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sent_req  <= '0;
         sent_resp <= '0;
      end
      else if (!csr_en)
      begin
         sent_req  <= '0;
         sent_resp <= '0;
      end
      else
      begin
         sent_req  <= sent_req  + {{(CRDT_W-1){1'b0}}, beat_req};
         sent_resp <= sent_resp + {{(CRDT_W-1){1'b0}}, beat_resp};
      end
   end

   // Counts lag by a cycle, so take off the beat in flight too
   assign avail_req  = rmt_crdt_req  - sent_req  - {{(CRDT_W-1){1'b0}}, beat_req};
   assign avail_resp = rmt_crdt_resp - sent_resp - {{(CRDT_W-1){1'b0}}, beat_resp};

   assign req_grant  = ~csr_crdt_en | (avail_req  >= crdt_t'(req_need));
   assign resp_grant = ~csr_crdt_en | (avail_resp >= crdt_t'(resp_need));

endmodule

/* logic/lumi_packet_sizer.sv */
//##########################################################################
// Decodes one UMI command into the bytes it needs on the link, the
// byte-valid start mask and the credit lines at the current beat width
//##########################################################################

module lumi_packet_sizer
  (
   input  umi_cmd_pkg::cmd_t         cmd,
   input  lumi_link_pkg::iowidth_t   csr_iowidth,
   output lumi_link_pkg::pkt_mask_t  start_mask,   // Bit 0 is the first byte out
   output lumi_link_pkg::bytecnt_t   crdt_need     // Lines for the whole packet
   );

   import lumi_link_pkg::*;
   import umi_cmd_pkg::*;

   opcode_t              opcode;
   size_t                size;
   len_t                 len;
   logic                 cmd_only;
   logic                 hdr_only;
   logic [BYTECNT_W+7:0] data_full;    // Wide enough for 256 << 7
   bytecnt_t             data_bytes;
   bytecnt_t             pkt_bytes;
   bytecnt_t             beat_bytes;

   // Command fields
   assign opcode = cmd[OP_MSB:OP_LSB];
   assign size   = cmd[SIZE_MSB:SIZE_LSB];
   assign len    = cmd[LEN_MSB:LEN_LSB];

   //########################################################################
   // Opcode class
   //########################################################################
   assign cmd_only = (opcode == OP_INVALID);

   always_comb
   begin
      case (opcode)
         OP_READ, OP_WRITE_RESP, OP_RDMA,
         OP_USER0, OP_FUTURE0, OP_ERROR : hdr_only = 1'b1;
         default                        : hdr_only = 1'b0;
      endcase
   end

   // (len+1) words of 2^size bytes, never more than one data field
   assign data_full  = ((BYTECNT_W+8)'(len) + 1'b1) << size;
   assign data_bytes = (data_full > DATA_BYTES) ? bytecnt_t'(DATA_BYTES) :
                       data_full[BYTECNT_W-1:0];

   assign pkt_bytes  = cmd_only ? bytecnt_t'(CMD_BYTES) :
                       hdr_only ? bytecnt_t'(HDR_BYTES) :
                       bytecnt_t'(HDR_BYTES) + data_bytes;

   // Low pkt_bytes bits set
   assign start_mask = ~({PKT_BYTES{1'b1}} << pkt_bytes);

   // Round up to whole beats
   assign beat_bytes = bytecnt_t'(1) << csr_iowidth;
   assign crdt_need  = (pkt_bytes + beat_bytes - 1'b1) >> csr_iowidth;

endmodule

/* logic/lumi_tx_arbiter.sv */
//##########################################################################
// Gates both streams by credit and PHY ready, picks the response first
// and packs the winner for the serializer
//##########################################################################

module lumi_tx_arbiter
  (
   input  logic                               csr_en,
   input  logic                               phy_txrdy,
   input  logic                               tx_idle,
   input  logic                               req_grant,
   input  logic                               resp_grant,
   // Request stream
   input  logic                               req_valid,
   input  umi_cmd_pkg::cmd_t                  req_cmd,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   req_dstaddr,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   req_srcaddr,
   input  logic [lumi_link_pkg::DATA_W-1:0]   req_data,
   input  lumi_link_pkg::pkt_mask_t           req_mask,
   // Response stream
   input  logic                               resp_valid,
   input  umi_cmd_pkg::cmd_t                  resp_cmd,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   resp_dstaddr,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   resp_srcaddr,
   input  logic [lumi_link_pkg::DATA_W-1:0]   resp_data,
   input  lumi_link_pkg::pkt_mask_t           resp_mask,
   // Handshake and serializer load
   output logic                               req_ready,
   output logic                               resp_ready,
   output logic                               load,
   output lumi_link_pkg::pkt_t                load_pkt,
   output lumi_link_pkg::pkt_mask_t           load_mask,
   output logic                               load_is_resp
   );

   import lumi_link_pkg::*;

   logic req_gated;
   logic resp_gated;
   logic accept_ok;      // Room in the shifter and link on

   // Valid qualified by credit and PHY back-pressure
   assign req_gated  = req_valid  & req_grant  & phy_txrdy;
   assign resp_gated = resp_valid & resp_grant & phy_txrdy;
   assign accept_ok  = csr_en & tx_idle;

   //########################################################################
   // Priority, response wins
   //########################################################################
   assign resp_ready   = accept_ok & resp_gated;
   assign req_ready    = accept_ok & req_gated & ~resp_gated;
   assign load         = req_ready | resp_ready;
   assign load_is_resp = resp_gated;

   // Cmd at the LSB, then dst, src, data
   assign load_pkt  = resp_gated ? {resp_data, resp_srcaddr, resp_dstaddr, resp_cmd} :
                                   {req_data, req_srcaddr, req_dstaddr, req_cmd};
   assign load_mask = resp_gated ? resp_mask : req_mask;

endmodule

/* lumi_tx/lumi_tx.sv */
//##########################################################################
// Transmit side of the chiplet link; merges UMI requests and responses
// onto one PHY lane with credit flow control, responses first
//##########################################################################

module lumi_tx
  (
   input  logic                               clk,
   input  logic                               nreset,
   // Control
   input  logic                               csr_en,       // 1 = link on
   input  logic                               csr_crdt_en,  // 0 = unlimited credits
   input  lumi_link_pkg::iowidth_t            csr_iowidth,  // log2 bytes per beat
   // Request stream
   input  logic                               req_valid,
   input  umi_cmd_pkg::cmd_t                  req_cmd,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   req_dstaddr,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   req_srcaddr,
   input  logic [lumi_link_pkg::DATA_W-1:0]   req_data,
   output logic                               req_ready,
   // Response stream
   input  logic                               resp_valid,
   input  umi_cmd_pkg::cmd_t                  resp_cmd,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   resp_dstaddr,
   input  logic [lumi_link_pkg::ADDR_W-1:0]   resp_srcaddr,
   input  logic [lumi_link_pkg::DATA_W-1:0]   resp_data,
   output logic                               resp_ready,
   // Remote credits, in lines
   input  lumi_link_pkg::crdt_t               rmt_crdt_req,
   input  lumi_link_pkg::crdt_t               rmt_crdt_resp,
   // PHY
   output lumi_link_pkg::lane_t               phy_txdata,
   output logic                               phy_txvld,
   input  logic                               phy_txrdy
   );

   import lumi_link_pkg::*;

   pkt_mask_t req_mask;      // Start masks from the sizers
   pkt_mask_t resp_mask;
   bytecnt_t  req_need;      // Lines each packet costs
   bytecnt_t  resp_need;
   logic      req_grant;
   logic      resp_grant;
   logic      tx_idle;       // Shifter empty or on last beat
   logic      beat_sent;
   logic      beat_is_resp;
   logic      load;
   pkt_t      load_pkt;
   pkt_mask_t load_mask;
   logic      load_is_resp;

   //########################################################################
   // Packet sizing, one per stream
   //########################################################################
   lumi_packet_sizer u_req_sizer
     (.cmd         (req_cmd),
      .csr_iowidth (csr_iowidth),
      .start_mask  (req_mask),
      .crdt_need   (req_need));

   lumi_packet_sizer u_resp_sizer
     (.cmd         (resp_cmd),
      .csr_iowidth (csr_iowidth),
      .start_mask  (resp_mask),
      .crdt_need   (resp_need));

   // Credit check per class
   lumi_credit_tracker u_credit
     (.clk           (clk),
      .nreset        (nreset),
      .csr_en        (csr_en),
      .csr_crdt_en   (csr_crdt_en),
      .rmt_crdt_req  (rmt_crdt_req),
      .rmt_crdt_resp (rmt_crdt_resp),
      .req_need      (req_need),
      .resp_need     (resp_need),
      .beat_sent     (beat_sent),
      .beat_is_resp  (beat_is_resp),
      .req_grant     (req_grant),
      .resp_grant    (resp_grant));

   lumi_tx_arbiter u_arbiter
     (.csr_en       (csr_en),
      .phy_txrdy    (phy_txrdy),
      .tx_idle      (tx_idle),
      .req_grant    (req_grant),
      .resp_grant   (resp_grant),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_mask     (req_mask),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_mask    (resp_mask),
      .req_ready    (req_ready),
      .resp_ready   (resp_ready),
      .load         (load),
      .load_pkt     (load_pkt),
      .load_mask    (load_mask),
      .load_is_resp (load_is_resp));

   // LSB first onto the lane
   lumi_tx_serializer u_serializer
     (.clk          (clk),
      .nreset       (nreset),
      .csr_iowidth  (csr_iowidth),
      .phy_txrdy    (phy_txrdy),
      .load         (load),
      .load_pkt     (load_pkt),
      .load_mask    (load_mask),
      .load_is_resp (load_is_resp),
      .phy_txdata   (phy_txdata),
      .phy_txvld    (phy_txvld),
      .tx_idle      (tx_idle),
      .beat_sent    (beat_sent),
      .beat_is_resp (beat_is_resp));

endmodule

/* lumi_tx/lumi_tx_serializer.sv */
//##########################################################################
// Packet shift register for the PHY lane; loads one packet and sends
// 2^csr_iowidth bytes per beat, LSB first, stalled by phy_txrdy
//##########################################################################

module lumi_tx_serializer
  (
   input  logic                      clk,
   input  logic                      nreset,
   input  lumi_link_pkg::iowidth_t   csr_iowidth,
   input  logic                      phy_txrdy,
   // From arbiter
   input  logic                      load,
   input  lumi_link_pkg::pkt_t       load_pkt,
   input  lumi_link_pkg::pkt_mask_t  load_mask,
   input  logic                      load_is_resp,
   // PHY
   output lumi_link_pkg::lane_t      phy_txdata,
   output logic                      phy_txvld,
   // Status
   output logic                      tx_idle,       // Can take a packet next edge
   output logic                      beat_sent,
   output logic                      beat_is_resp
   );

   import lumi_link_pkg::*;

   pkt_t      shift_reg;
   pkt_mask_t byte_mask;     // Bytes still to send
   pkt_mask_t mask_next;
   logic      is_resp;       // Class of the packet in flight
   bytecnt_t  beat_bytes;
   bytecnt_t  beat_bits;

   // Beat width
   assign beat_bytes = bytecnt_t'(1) << csr_iowidth;
   assign beat_bits  = beat_bytes << 3;
   assign mask_next  = byte_mask >> beat_bytes;

   //########################################################################
   // Byte mask and class
   //########################################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         byte_mask <= '0;
         is_resp   <= 1'b0;
      end
      else if (load)
      begin
         byte_mask <= load_mask;
         is_resp   <= load_is_resp;
      end
      else if (phy_txrdy)
         byte_mask <= mask_next;     // One beat gone
   end

   //########################################################################
   // Data shift register
   //########################################################################
   always_ff @(posedge clk)
   begin
      if (load)
         shift_reg <= load_pkt;
      else if (phy_txrdy)
         shift_reg <= shift_reg >> beat_bits;
   end

   // Upper lane bytes unused in narrow modes
   assign phy_txdata   = shift_reg[LANE_W-1:0];
   assign phy_txvld    = |byte_mask;

   // Idle also on the last beat, so the next packet follows without a gap
   assign tx_idle      = ~|mask_next;
   assign beat_sent    = phy_txvld & phy_txrdy;
   assign beat_is_resp = is_resp;

endmodule

/* project.f */
common/lumi_link_pkg.sv
common/umi_cmd_pkg.sv
logic/lumi_packet_sizer.sv
logic/lumi_credit_tracker.sv
logic/lumi_tx_arbiter.sv
lumi_tx/lumi_tx_serializer.sv
lumi_tx/lumi_tx.sv
verification/tb_clock_gen.sv
verification/lumi_tx_asserts.sv
verification/tb_lumi_tx.sv

/* verification/lumi_tx_asserts.sv */
//##########################################################################
// Concurrent checks on the transmit top level, bound into every lumi_tx
//##########################################################################

module lumi_tx_asserts
  (
   input logic                  clk,
   input logic                  nreset,
   input logic                  req_ready,
   input logic                  resp_ready,
   input lumi_link_pkg::lane_t  phy_txdata,
   input logic                  phy_txvld,
   input logic                  phy_txrdy
   );

   int fail_count = 0;        // Read by the testbench at the end

   // One stream per accept
   one_ready : assert property (@(posedge clk) disable iff (!nreset)
                                !(req_ready && resp_ready))
      else
      begin
         fail_count++;
         $error("req_ready and resp_ready high in the same cycle");
      end

   // Stalled beat holds its data
   hold_data : assert property (@(posedge clk) disable iff (!nreset)
                                (phy_txvld && !phy_txrdy) |=> $stable(phy_txdata))
      else
      begin
         fail_count++;
         $error("phy_txdata changed during a PHY stall");
      end

   // Nothing on the lane right after reset
   idle_after_reset : assert property (@(posedge clk) $rose(nreset) |-> !phy_txvld)
      else
      begin
         fail_count++;
         $error("phy_txvld high in the first cycle after reset");
      end

endmodule

bind lumi_tx lumi_tx_asserts u_asserts
  (.clk        (clk),
   .nreset     (nreset),
   .req_ready  (req_ready),
   .resp_ready (resp_ready),
   .phy_txdata (phy_txdata),
   .phy_txvld  (phy_txvld),
   .phy_txrdy  (phy_txrdy));

/* verification/tb_clock_gen.sv */
//##########################################################################
// Testbench clock and reset; clk period 100, nreset low for 10 cycles
//##########################################################################

module tb_clock_gen
  (
   output logic clk,
   output logic nreset
   );

   localparam int HALF_PERIOD = 50;
   localparam int RESET_CYCLES = 10;

   initial
   begin
      clk    = 1'b0;
      nreset = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;           // Release away from the rising edge
   end

   always #HALF_PERIOD clk = ~clk;

endmodule

/* verification/tb_lumi_tx.sv */
//##########################################################################
// Table-driven testbench for the link transmit path; drives both UMI
// streams, collects PHY beats and compares them with a packet model
//##########################################################################

module tb_lumi_tx;

   import lumi_link_pkg::*;
   import umi_cmd_pkg::*;

   localparam logic [1:0] M_REQ = 2'd0, M_RESP = 2'd1, M_BOTH = 2'd2, M_OFF = 2'd3;
   localparam int NROWS = 20;
   localparam int LIMIT = NROWS * 40 + 100;   // Cycles for the whole run

   typedef struct packed {
      logic [1:0] mode;       // Stream under test, or link off
      opcode_t    op;
      len_t       len;
      size_t      size;
      iowidth_t   iow;
      logic       crdt_en;
      crdt_t      rmt_req;
      crdt_t      rmt_resp;
      logic       stall;      // Random phy_txrdy stretches
   } row_t;

   logic clk, nreset, csr_en, csr_crdt_en, req_valid, resp_valid, req_ready, resp_ready;
   logic phy_txvld;
   logic phy_txrdy = 1'b1;
   iowidth_t csr_iowidth;
   cmd_t req_cmd, resp_cmd;
   logic [ADDR_W-1:0] req_dstaddr, req_srcaddr, resp_dstaddr, resp_srcaddr;
   logic [DATA_W-1:0] req_data, resp_data;
   crdt_t rmt_crdt_req, rmt_crdt_resp;
   lane_t phy_txdata;

   row_t   rows [NROWS];
   lane_t  beat_q[$];          // Beats seen on the lane
   lane_t  exp_q[$];           // Model beats, valid bytes only
   int     exp_vld_q[$];
   integer seed = 32'h0a81e17c;
   int     errors = 0;
   int     checks = 0;
   int     cycles = 0;
   int     stall_left = 0;
   logic   stall_en = 1'b0;

   tb_clock_gen u_clk (.clk(clk), .nreset(nreset));

   lumi_tx uut (.*);

   //########################################################################
   // Compare tasks, one per result type
   //########################################################################
   task automatic check_lane(input string name, input lane_t got, input lane_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_count(input string name, input bytecnt_t got, input bytecnt_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, got);
      end
   endtask

   //########################################################################
   // Packet model
   //########################################################################
   function automatic lane_t low_bytes(input int n);
      lane_t m;
      m = '0;
      for (int k = 0; k < n; k++)
         m[8*k +: 8] = 8'hff;
      return m;
   endfunction

   // Link bytes by opcode class, data capped at one data field
   function automatic int packet_bytes(input opcode_t op, input len_t len, input size_t size);
      int data;
      if (op == OP_INVALID)
         return CMD_BYTES;
      if (op inside {OP_READ, OP_WRITE_RESP, OP_RDMA, OP_USER0, OP_FUTURE0, OP_ERROR})
         return HDR_BYTES;
      data = (int'(len) + 1) << size;
      return HDR_BYTES + ((data > DATA_BYTES) ? DATA_BYTES : data);
   endfunction

   // Cuts one packet into beats, LSB first
   task automatic add_expected(input cmd_t cmd, input logic [ADDR_W-1:0] dst,
                               input logic [ADDR_W-1:0] src, input logic [DATA_W-1:0] data,
                               input iowidth_t iow);
      pkt_t pkt;
      int   left;
      int   bpb;
      int   nvld;
      pkt  = {data, src, dst, cmd};
      left = packet_bytes(cmd[4:0], cmd[15:8], cmd[7:5]);
      bpb  = 1 << iow;
      while (left > 0)
      begin
         nvld = (left < bpb) ? left : bpb;
         exp_q.push_back(pkt[LANE_W-1:0] & low_bytes(nvld));
         exp_vld_q.push_back(nvld);
         pkt  = pkt >> (8 * bpb);
         left = left - nvld;
      end
   endtask

   //########################################################################
   // One table row
   //########################################################################
   task automatic run_test(input int idx);
      row_t r;
      int   need;
      int   errs_before;
      int   i;
      logic want_req, want_resp, starved, first, resp_done, took_req, took_resp;
      r = rows[idx];
      errs_before = errors;
      beat_q.delete();
      exp_q.delete();
      exp_vld_q.delete();
      @(negedge clk);
      csr_en        = 1'b0;                 // Clears the credit counts
      req_cmd       = $random(seed);
      resp_cmd      = $random(seed);
      req_cmd[15:0] = {r.len, r.size, r.op};
      resp_cmd[15:0] = {r.len, r.size, r.op};
      req_dstaddr   = {$random(seed), $random(seed)};
      req_srcaddr   = {$random(seed), $random(seed)};
      resp_dstaddr  = {$random(seed), $random(seed)};
      resp_srcaddr  = {$random(seed), $random(seed)};
      req_data      = {$random(seed), $random(seed), $random(seed), $random(seed)};
      resp_data     = {$random(seed), $random(seed), $random(seed), $random(seed)};
      csr_crdt_en   = r.crdt_en;
      csr_iowidth   = r.iow;
      rmt_crdt_req  = r.rmt_req;
      rmt_crdt_resp = r.rmt_resp;
      want_req  = (r.mode == M_REQ) || (r.mode == M_BOTH);
      want_resp = (r.mode == M_RESP) || (r.mode == M_BOTH);
      if (want_resp)
         add_expected(resp_cmd, resp_dstaddr, resp_srcaddr, resp_data, r.iow);   // Goes first
      if (want_req)
         add_expected(req_cmd, req_dstaddr, req_srcaddr, req_data, r.iow);
      need    = (packet_bytes(r.op, r.len, r.size) + (1 << r.iow) - 1) >> r.iow;
      starved = want_req && r.crdt_en && (r.rmt_req < need);
      @(posedge clk);
      stall_en = r.stall;
      @(negedge clk);
      csr_en     = (r.mode != M_OFF);
      req_valid  = want_req || (r.mode == M_OFF);
      resp_valid = want_resp || (r.mode == M_OFF);
      if (r.mode == M_OFF)
      begin
         repeat (10)
         begin
            @(posedge clk);
            check_bit("req_ready", req_ready, 1'b0);
            check_bit("resp_ready", resp_ready, 1'b0);
         end
         @(negedge clk);
         req_valid  = 1'b0;
         resp_valid = 1'b0;
         csr_en     = 1'b1;
      end
      if (starved)
      begin
         repeat (8)
         begin
            @(posedge clk);
            check_bit("req_ready", req_ready, 1'b0);
         end
         @(negedge clk);
         rmt_crdt_req = crdt_t'(need);      // Just enough lines
      end
      first     = !r.stall && !starved;
      resp_done = 1'b0;
      while (req_valid || resp_valid)
      begin
         @(posedge clk);
         if (first)
         begin
            check_bit("resp_ready", resp_ready, want_resp);
            check_bit("req_ready", req_ready, want_req && !want_resp);
            first = 1'b0;
         end
         if (!phy_txrdy)
         begin
            check_bit("req_ready", req_ready, 1'b0);     // No accept in a stall
            check_bit("resp_ready", resp_ready, 1'b0);
         end
         took_req  = req_valid && req_ready;
         took_resp = resp_valid && resp_ready;
         if (took_req)
            check_bit("resp_done", resp_done, want_resp);
         if (took_resp)
            resp_done = 1'b1;
         @(negedge clk);
         if (took_req)
            req_valid = 1'b0;
         if (took_resp)
            resp_valid = 1'b0;
      end
      while (beat_q.size() < exp_q.size())
         @(negedge clk);
      stall_en = 1'b0;
      repeat (2) @(negedge clk);             // Catch stray beats
      check_count("beat count", bytecnt_t'(beat_q.size()), bytecnt_t'(exp_q.size()));
      for (i = 0; i < exp_q.size() && i < beat_q.size(); i++)
         check_lane($sformatf("phy_txdata beat %0d", i),
                    beat_q[i] & low_bytes(exp_vld_q[i]), exp_q[i]);
      check_bit("phy_txvld", phy_txvld, 1'b0);
      $display("Test %0d (mode %0d, iowidth %0d) %0d beats: %s", idx, r.mode, r.iow,
               beat_q.size(), (errors == errs_before) ? "ok" : "FAILED");
   endtask

   //########################################################################
   // Lane collector, PHY stalls and run limit
   //########################################################################
   always @(posedge clk)
   begin
      if (phy_txvld && phy_txrdy)
         beat_q.push_back(phy_txdata);      // Beat taken by the PHY
   end

   always @(negedge clk)
   begin
      if (!stall_en)
         phy_txrdy = 1'b1;
      else if (stall_left > 0)
         stall_left--;
      else
      begin
         phy_txrdy  = ~phy_txrdy;
         stall_left = $unsigned($random(seed)) % 4;
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= LIMIT)
      begin
         $display("Timeout after %0d cycles, a packet never left the lane", cycles);
         $display("Finished with errors");
         $finish;
      end
   end

   initial
   begin
      int t;
      csr_en = 1'b1;
      csr_crdt_en = 1'b0;
      csr_iowidth = '0;
      req_valid = 1'b0;
      resp_valid = 1'b0;
      {req_cmd, req_dstaddr, req_srcaddr, req_data} = '0;
      {resp_cmd, resp_dstaddr, resp_srcaddr, resp_data} = '0;
      rmt_crdt_req = '0;
      rmt_crdt_resp = '0;
      //          mode    opcode         len    size  iow  crdt  rmt_req rmt_resp stall
      rows[0]  = '{M_REQ,  OP_INVALID,    8'd0,  3'd0, 2'd0, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[1]  = '{M_REQ,  OP_READ,       8'h12, 3'd2, 2'd1, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[2]  = '{M_RESP, OP_WRITE_RESP, 8'd0,  3'd0, 2'd2, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[3]  = '{M_REQ,  5'h03,         8'd0,  3'd0, 2'd3, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[4]  = '{M_REQ,  5'h03,         8'd3,  3'd1, 2'd2, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[5]  = '{M_RESP, 5'h02,         8'd1,  3'd2, 2'd0, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[6]  = '{M_REQ,  5'h03,         8'd7,  3'd3, 2'd3, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[7]  = '{M_REQ,  5'h05,         8'd255, 3'd7, 2'd1, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[8]  = '{M_RESP, OP_ERROR,      8'd0,  3'd0, 2'd3, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[9]  = '{M_REQ,  OP_USER0,      8'd0,  3'd0, 2'd0, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[10] = '{M_RESP, OP_FUTURE0,    8'd0,  3'd0, 2'd2, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[11] = '{M_BOTH, 5'h03,         8'd1,  3'd2, 2'd3, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[12] = '{M_BOTH, OP_RDMA,       8'd0,  3'd0, 2'd2, 1'b0, 16'd0, 16'd0, 1'b0};
      rows[13] = '{M_REQ,  5'h03,         8'd3,  3'd2, 2'd2, 1'b1, 16'd4, 16'd0, 1'b0};
      rows[14] = '{M_REQ,  5'h03,         8'd3,  3'd2, 2'd2, 1'b0, 16'd4, 16'd0, 1'b0};
      rows[15] = '{M_RESP, 5'h02,         8'd0,  3'd3, 2'd3, 1'b1, 16'd0, 16'd4, 1'b0};
      rows[16] = '{M_REQ,  5'h03,         8'd15, 3'd0, 2'd2, 1'b0, 16'd0, 16'd0, 1'b1};
      rows[17] = '{M_BOTH, 5'h05,         8'd3,  3'd0, 2'd3, 1'b0, 16'd0, 16'd0, 1'b1};
      rows[18] = '{M_RESP, OP_READ,       8'd0,  3'd0, 2'd1, 1'b0, 16'd0, 16'd0, 1'b1};
      rows[19] = '{M_OFF,  OP_READ,       8'd0,  3'd0, 2'd2, 1'b0, 16'd0, 16'd0, 1'b0};
      wait (nreset);
      for (t = 0; t < NROWS; t++)
         run_test(t);
      $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
               NROWS, checks, errors, uut.u_asserts.fail_count);
      if (errors == 0 && uut.u_asserts.fail_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule
